// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;

  // rv32i major opcodes, only the implemented subset
  typedef enum logic [6:0] {
    OP_IMM    = 7'b001_0011,
    OP_LUI    = 7'b011_0111,
    OP_AUIPC  = 7'b001_0111,
    OP_JAL    = 7'b110_1111,
    OP_JALR   = 7'b110_0111,
    OP_LOAD   = 7'b000_0011,
    OP_STORE  = 7'b010_0011,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // first adder operand
  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } op_a_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_PC4  = 2'd1,
    WB_LOAD = 2'd2
  } wb_sel_e;

  // load/store width codes (funct3)
  localparam logic [2:0] FUNCT3_B  = 3'b000;
  localparam logic [2:0] FUNCT3_H  = 3'b001;
  localparam logic [2:0] FUNCT3_W  = 3'b010;
  localparam logic [2:0] FUNCT3_BU = 3'b100;
  localparam logic [2:0] FUNCT3_HU = 3'b101;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    word_t                 imm;
    op_a_e                 op_a;
    wb_sel_e               wb_sel;
    logic                  reg_we;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  jump;   // next pc comes from the adder
    logic                  halt;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    logic       rd_en;
    logic       wr_en;
    word_t      wdata;  // already in its byte lane
    logic [3:0] wmask;
  } dmem_req_t;

endpackage

// ==== hdl/pc_stage.sv ====
`timescale 1ns/1ps

module pc_stage #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               jump,
  input  logic               halt,
  input  rv_core_pkg::word_t target,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t pc_plus4
);

  rv_core_pkg::word_t pc_next;

  assign pc_plus4 = pc + 32'd4;
  assign pc_next  = jump ? target : pc_plus4; // jal/jalr take the adder result

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halt) begin // ebreak freezes the core
      pc <= pc_next;
    end
  end

  // jump targets come back from execute, so this covers the whole loop
  pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic               rst_n,
  input  rv_core_pkg::word_t inst,
  output rv_core_pkg::ctrl_t ctrl
);

  localparam rv_core_pkg::word_t EBREAK = 32'h0010_0073;

  logic [2:0]         funct3;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;
  logic               load_ok;
  logic               store_ok;

  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // unsupported widths fall through as no-ops
  assign load_ok = funct3 inside {rv_core_pkg::FUNCT3_B, rv_core_pkg::FUNCT3_H,
                                  rv_core_pkg::FUNCT3_W, rv_core_pkg::FUNCT3_BU,
                                  rv_core_pkg::FUNCT3_HU};
  assign store_ok = funct3 inside {rv_core_pkg::FUNCT3_B, rv_core_pkg::FUNCT3_H,
                                   rv_core_pkg::FUNCT3_W};

  always_comb begin
    ctrl        = '0;
    ctrl.rd     = inst[11:7];
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.funct3 = funct3;
    ctrl.imm    = imm_i;
    ctrl.op_a   = rv_core_pkg::A_ZERO;
    ctrl.wb_sel = rv_core_pkg::WB_ALU;

    case (inst[6:0])
      rv_core_pkg::OP_IMM: begin
        if (funct3 == 3'b000) begin // addi only
          ctrl.reg_we = 1'b1;
          ctrl.op_a   = rv_core_pkg::A_RS1;
        end
      end
      rv_core_pkg::OP_LUI: begin
        ctrl.reg_we = 1'b1;
        ctrl.imm    = imm_u;
      end
      rv_core_pkg::OP_AUIPC: begin
        ctrl.reg_we = 1'b1;
        ctrl.op_a   = rv_core_pkg::A_PC;
        ctrl.imm    = imm_u;
      end
      rv_core_pkg::OP_JAL: begin
        ctrl.reg_we = 1'b1;
        ctrl.op_a   = rv_core_pkg::A_PC;
        ctrl.imm    = imm_j;
        ctrl.wb_sel = rv_core_pkg::WB_PC4;
        ctrl.jump   = 1'b1;
      end
      rv_core_pkg::OP_JALR: begin
        if (funct3 == 3'b000) begin // target bit 0 dropped in execute
          ctrl.reg_we = 1'b1;
          ctrl.op_a   = rv_core_pkg::A_RS1;
          ctrl.wb_sel = rv_core_pkg::WB_PC4;
          ctrl.jump   = 1'b1;
        end
      end
      rv_core_pkg::OP_LOAD: begin
        if (load_ok) begin
          ctrl.reg_we = 1'b1;
          ctrl.op_a   = rv_core_pkg::A_RS1;
          ctrl.wb_sel = rv_core_pkg::WB_LOAD;
          ctrl.mem_rd = 1'b1;
        end
      end
      rv_core_pkg::OP_STORE: begin
        if (store_ok) begin
          ctrl.op_a   = rv_core_pkg::A_RS1;
          ctrl.imm    = imm_s;
          ctrl.mem_wr = 1'b1;
        end
      end
      rv_core_pkg::OP_SYSTEM: ctrl.halt = (inst == EBREAK);
      default: ;
    endcase

    // no side effects while the core sits in reset
    if (!rst_n) begin
      ctrl.reg_we = 1'b0;
      ctrl.mem_rd = 1'b0;
      ctrl.mem_wr = 1'b0;
      ctrl.halt   = 1'b0;
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0]  rd,
  input  logic                                we,
  input  rv_core_pkg::word_t                  wdata,
  output rv_core_pkg::word_t                  rs1_data,
  output rv_core_pkg::word_t                  rs2_data
);

  localparam int NREGS = 2**rv_core_pkg::REG_ADDR_W;

  rv_core_pkg::word_t regs [1:NREGS-1]; // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // async read, x0 hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t pc,
  input  rv_core_pkg::word_t rs1_data,
  output rv_core_pkg::word_t alu_result
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t sum;
  logic               is_jalr;

  always_comb begin
    case (ctrl.op_a)
      rv_core_pkg::A_RS1: op_a = rs1_data;
      rv_core_pkg::A_PC:  op_a = pc;
      default:            op_a = '0; // lui
    endcase
  end

  // one adder for addi, lui, auipc, jump targets and load/store addresses
  assign sum = op_a + ctrl.imm;

  // jal's sum is always even, only the register-based jump needs the mask
  assign is_jalr = ctrl.jump && (ctrl.op_a == rv_core_pkg::A_RS1);

  assign alu_result = is_jalr ? {sum[31:1], 1'b0} : sum;

endmodule

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  rv_core_pkg::word_t     alu_result,
  input  rv_core_pkg::word_t     rs2_data,
  input  rv_core_pkg::word_t     pc_plus4,
  input  rv_core_pkg::word_t     dmem_rdata,
  output rv_core_pkg::dmem_req_t dmem_req,
  output rv_core_pkg::word_t     wb_data,
  output logic                   wb_en
);

  logic [1:0]         offset;
  rv_core_pkg::word_t lane;       // rdata shifted so the addressed byte is at bit 0
  rv_core_pkg::word_t load_data;
  rv_core_pkg::word_t store_data;
  logic [3:0]         store_mask;

  assign offset = alu_result[1:0];
  assign lane   = dmem_rdata >> {offset, 3'b000};

  // store side, data replicated so every lane carries it
  always_comb begin
    store_data = '0;
    store_mask = 4'b0000;
    case (ctrl.funct3)
      rv_core_pkg::FUNCT3_B: begin
        store_data = {4{rs2_data[7:0]}};
        store_mask = 4'b0001 << offset;
      end
      rv_core_pkg::FUNCT3_H: begin
        store_data = {2{rs2_data[15:0]}};
        if (!offset[0]) store_mask = offset[1] ? 4'b1100 : 4'b0011;
      end
      rv_core_pkg::FUNCT3_W: begin
        store_data = rs2_data;
        if (offset == 2'b00) store_mask = 4'b1111;
      end
      default: ;
    endcase
  end

  // load side; misaligned halves and words return zero
  always_comb begin
    load_data = '0;
    case (ctrl.funct3)
      rv_core_pkg::FUNCT3_B:  load_data = {{24{lane[7]}}, lane[7:0]};
      rv_core_pkg::FUNCT3_BU: load_data = {24'h0, lane[7:0]};
      rv_core_pkg::FUNCT3_H:  if (!offset[0]) load_data = {{16{lane[15]}}, lane[15:0]};
      rv_core_pkg::FUNCT3_HU: if (!offset[0]) load_data = {16'h0, lane[15:0]};
      rv_core_pkg::FUNCT3_W:  if (offset == 2'b00) load_data = dmem_rdata;
      default: ;
    endcase
  end

  assign dmem_req.addr  = alu_result;
  assign dmem_req.rd_en = ctrl.mem_rd;
  assign dmem_req.wr_en = ctrl.mem_wr;
  assign dmem_req.wdata = store_data;
  assign dmem_req.wmask = ctrl.mem_wr ? store_mask : 4'b0000;

  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::WB_PC4:  wb_data = pc_plus4;  // link address
      rv_core_pkg::WB_LOAD: wb_data = load_data;
      default:              wb_data = alu_result;
    endcase
  end

  assign wb_en = ctrl.reg_we;

  // catches a misaligned store address reaching memory
  always_comb begin
    if (dmem_req.wr_en) begin
      assert (dmem_req.wmask != 4'b0000)
        else $error("store with empty mask at %h", dmem_req.addr);
    end
  end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::word_t     pc,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  rv_core_pkg::word_t     dmem_rdata,
  output logic                   halt
);

  rv_core_pkg::ctrl_t ctrl;
  rv_core_pkg::word_t pc_plus4;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t wb_data;
  logic               wb_en;

  assign halt = ctrl.halt;

  pc_stage #(
    .RESET_PC (RESET_PC)
  ) i_pc_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .jump     (ctrl.jump),
    .halt     (ctrl.halt),
    .target   (alu_result),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  decode_stage i_decode_stage (
    .rst_n (rst_n),
    .inst  (inst),
    .ctrl  (ctrl)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .we       (wb_en),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage i_execute_stage (
    .ctrl       (ctrl),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .alu_result (alu_result)
  );

  mem_wb_stage i_mem_wb_stage (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .wb_data    (wb_data),
    .wb_en      (wb_en)
  );

endmodule

// ==== sim/tb_rv_core_tests.svh ====
function automatic rv_core_pkg::word_t imm_insn(logic [11:0] imm, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_core_pkg::word_t store_insn(logic [11:0] imm, logic [4:0] rs2,
                                                  logic [4:0] rs1, logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OP_STORE};
endfunction

function automatic rv_core_pkg::word_t upper_insn(logic [19:0] imm, logic [4:0] rd,
                                                  logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic rv_core_pkg::word_t jal_insn(logic [20:0] off, logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OP_JAL};
endfunction

// hold the core in reset and fill the program with nops
task automatic enter_reset();
  @(posedge clk);
  rst_n <= 1'b0;
  @(negedge clk);
  for (int i = 0; i < 64; i++) begin
    imem[i] = imm_insn(12'd0, 5'd0, 3'b000, 5'd0, rv_core_pkg::OP_IMM);
  end
  imem[0] = upper_insn(20'h80000, 5'd1, rv_core_pkg::OP_LUI); // x1 = data base
endtask

task automatic leave_reset();
  repeat (RESET_CYCLES - 1) begin
    @(negedge clk);
    check_word("pc", pc, BASE);
    check_bit("dmem_req.rd_en", dmem_req.rd_en, 1'b0);
    check_bit("dmem_req.wr_en", dmem_req.wr_en, 1'b0);
    check_bit("halt", halt, 1'b0);
  end
  @(posedge clk);
  rst_n <= 1'b1;
endtask

task automatic wait_for_store(rv_core_pkg::word_t exp_addr, rv_core_pkg::word_t exp_data,
                              logic [3:0] exp_mask);
  int                 n;
  rv_core_pkg::word_t lanes;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!dmem_req.wr_en && n < STEP_LIMIT);
  if (!dmem_req.wr_en) begin
    report_failure($sformatf("no store seen for address %h within %0d cycles",
                             exp_addr, STEP_LIMIT));
  end
  for (int b = 0; b < 4; b++) begin
    lanes[8*b +: 8] = {8{exp_mask[b]}};
  end
  check_mask("dmem_req.wmask", dmem_req.wmask, exp_mask);
  check_word("dmem_req.addr", dmem_req.addr, exp_addr);
  check_word("dmem_req.wdata", dmem_req.wdata & lanes, exp_data);
endtask

task automatic reset_and_sequencing();
  enter_reset();
  // a load sits at the reset address, so rd_en must stay low until reset ends
  imem[0] = imm_insn(12'd0, 5'd0, rv_core_pkg::FUNCT3_W, 5'd1, rv_core_pkg::OP_LOAD);
  for (int k = 1; k < 6; k++) begin
    imem[k] = imm_insn(12'($urandom), 5'd0, 3'b000, 5'(k + 1), rv_core_pkg::OP_IMM);
  end
  leave_reset();
  for (int k = 0; k < 6; k++) begin
    @(negedge clk);
    check_word("pc", pc, BASE + 32'(4 * k));
    check_bit("dmem_req.rd_en", dmem_req.rd_en, k == 0);
    check_bit("dmem_req.wr_en", dmem_req.wr_en, 1'b0);
    check_bit("halt", halt, 1'b0);
  end
endtask

task automatic arithmetic_ops();
  logic [11:0] imm_a;
  logic [11:0] imm_b;
  logic [19:0] upper;
  imm_a = 12'($urandom);
  imm_b = 12'($urandom);
  upper = 20'($urandom);
  enter_reset();
  imem[1] = upper_insn(upper, 5'd2, rv_core_pkg::OP_LUI);
  imem[2] = imm_insn(imm_a, 5'd2, 3'b000, 5'd2, rv_core_pkg::OP_IMM);
  imem[3] = store_insn(12'd0, 5'd2, 5'd1, rv_core_pkg::FUNCT3_W);
  imem[4] = upper_insn(upper, 5'd3, rv_core_pkg::OP_AUIPC); // at BASE + 16
  imem[5] = store_insn(12'd4, 5'd3, 5'd1, rv_core_pkg::FUNCT3_W);
  imem[6] = imm_insn(imm_b, 5'd0, 3'b000, 5'd4, rv_core_pkg::OP_IMM);
  imem[7] = store_insn(12'd8, 5'd4, 5'd1, rv_core_pkg::FUNCT3_W);
  leave_reset();
  wait_for_store(BASE, {upper, 12'h000} + {{20{imm_a[11]}}, imm_a}, 4'b1111);
  wait_for_store(BASE + 32'd4, BASE + 32'd16 + {upper, 12'h000}, 4'b1111);
  wait_for_store(BASE + 32'd8, {{20{imm_b[11]}}, imm_b}, 4'b1111);
endtask

task automatic store_lanes();
  logic [19:0]        upper;
  logic [11:0]        low;
  rv_core_pkg::word_t value;
  upper = 20'($urandom);
  low   = 12'($urandom);
  value = {upper, 12'h000} + {{20{low[11]}}, low};
  enter_reset();
  imem[1] = upper_insn(upper, 5'd2, rv_core_pkg::OP_LUI);
  imem[2] = imm_insn(low, 5'd2, 3'b000, 5'd2, rv_core_pkg::OP_IMM);
  for (int k = 0; k < 4; k++) begin
    imem[3 + k] = store_insn(12'(16 + k), 5'd2, 5'd1, rv_core_pkg::FUNCT3_B);
  end
  imem[7] = store_insn(12'd20, 5'd2, 5'd1, rv_core_pkg::FUNCT3_H);
  imem[8] = store_insn(12'd22, 5'd2, 5'd1, rv_core_pkg::FUNCT3_H);
  leave_reset();
  for (int k = 0; k < 4; k++) begin
    wait_for_store(BASE + 32'd16 + 32'(k), {24'h0, value[7:0]} << (8 * k), 4'b0001 << k);
  end
  wait_for_store(BASE + 32'd20, {16'h0, value[15:0]}, 4'b0011);
  wait_for_store(BASE + 32'd22, {value[15:0], 16'h0}, 4'b1100);
endtask

task automatic load_extension();
  logic [2:0]         widths [5];
  logic [11:0]        offsets [5];
  rv_core_pkg::word_t words [5];
  rv_core_pkg::word_t exp_words [5];
  widths  = '{rv_core_pkg::FUNCT3_B, rv_core_pkg::FUNCT3_BU, rv_core_pkg::FUNCT3_H,
              rv_core_pkg::FUNCT3_HU, rv_core_pkg::FUNCT3_W};
  offsets = '{12'd17, 12'd23, 12'd26, 12'd28, 12'd32};
  enter_reset();
  for (int k = 0; k < 5; k++) begin
    words[k] = $urandom | 32'h8000_8000; // top bit of every picked lane set
    dmem[4 + k] <= words[k];
    imem[1 + 2 * k] = imm_insn(offsets[k], 5'd1, widths[k], 5'd5, rv_core_pkg::OP_LOAD);
    imem[2 + 2 * k] = store_insn(12'(64 + 4 * k), 5'd5, 5'd1, rv_core_pkg::FUNCT3_W);
  end
  exp_words[0] = {{24{words[0][15]}}, words[0][15:8]};
  exp_words[1] = {24'h0, words[1][31:24]};
  exp_words[2] = {{16{words[2][31]}}, words[2][31:16]};
  exp_words[3] = {16'h0, words[3][15:0]};
  exp_words[4] = words[4];
  leave_reset();
  for (int k = 0; k < 5; k++) begin
    wait_for_store(BASE + 32'(64 + 4 * k), exp_words[k], 4'b1111);
  end
endtask

task automatic jump_targets();
  enter_reset();
  imem[1] = jal_insn(21'd12, 5'd5);                                  // 4 to 16
  imem[2] = store_insn(12'd96, 5'd0, 5'd1, rv_core_pkg::FUNCT3_W);   // skipped
  imem[3] = imem[2];
  imem[4] = store_insn(12'd0, 5'd5, 5'd1, rv_core_pkg::FUNCT3_W);
  imem[5] = upper_insn(20'h0, 5'd6, rv_core_pkg::OP_AUIPC);          // x6 = BASE + 20
  imem[6] = imm_insn(12'd13, 5'd6, 3'b000, 5'd7, rv_core_pkg::OP_JALR);
  imem[7] = imem[2];
  imem[8] = store_insn(12'd4, 5'd7, 5'd1, rv_core_pkg::FUNCT3_W);
  leave_reset();
  wait_for_store(BASE, BASE + 32'd8, 4'b1111);
  check_word("pc", pc, BASE + 32'd16);
  wait_for_store(BASE + 32'd4, BASE + 32'd28, 4'b1111);
  check_word("pc", pc, BASE + 32'd32); // odd target 33 lands on 32
endtask

task automatic halt_on_ebreak();
  int n;
  enter_reset();
  imem[2] = imm_insn(12'd1, 5'd0, 3'b000, 5'd0, rv_core_pkg::OP_SYSTEM);
  imem[3] = store_insn(12'd96, 5'd0, 5'd1, rv_core_pkg::FUNCT3_W);
  leave_reset();
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!halt && n < STEP_LIMIT);
  if (!halt) begin
    report_failure("halt never went high after ebreak");
  end
  check_word("pc", pc, BASE + 32'd8);
  repeat (3) begin
    @(negedge clk);
    check_bit("halt", halt, 1'b1);
    check_word("pc", pc, BASE + 32'd8);
    check_bit("dmem_req.wr_en", dmem_req.wr_en, 1'b0);
  end
endtask

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam rv_core_pkg::word_t BASE = 32'h8000_0000;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int STEP_LIMIT   = 24;  // longest program run after reset, in cycles
  localparam int NUM_TESTS    = 6;
  localparam int BUDGET       = NUM_TESTS * (RESET_CYCLES + 2 + STEP_LIMIT) + 50;

  logic                   clk;
  logic                   rst_n;
  rv_core_pkg::word_t     inst;
  rv_core_pkg::word_t     pc;
  rv_core_pkg::dmem_req_t dmem_req;
  rv_core_pkg::word_t     dmem_rdata;
  logic                   halt;

  rv_core_pkg::word_t imem [64];
  rv_core_pkg::word_t dmem [64];

  rv_core_top #(
    .RESET_PC (BASE)
  ) i_rv_core_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 256 byte memories, mirrored over the address space
  assign inst       = imem[pc[7:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    if (rst_n && dmem_req.wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wmask[b]) begin
          dmem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic report_failure(string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s got %h expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_mask(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s got %b expected %b",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s got %b expected %b",
                               $time, name, got, exp));
    end
  endtask

  `include "tb_rv_core_tests.svh"

  initial begin
    #(BUDGET * CLK_PERIOD);
    report_failure($sformatf("watchdog expired after %0d cycles", BUDGET));
  end

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    void'($urandom(66));
    for (int i = 0; i < 64; i++) begin
      dmem[i] = $urandom;
    end
    reset_and_sequencing();
    arithmetic_ops();
    store_lanes();
    load_extension();
    jump_targets();
    halt_on_ebreak();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+sim
hdl/rv_core_pkg.sv
hdl/pc_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_core_top.sv
sim/tb_rv_core.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert
TOP   := tb_rv_core
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
